//--- rtl/avm_pkg.sv
package avm_pkg;

    // register map of the RS-232 block, byte addresses on the Avalon bus.
    localparam logic [4:0] rx_base     = 5'd0;
    localparam logic [4:0] tx_base     = 5'd4;
    localparam logic [4:0] status_base = 5'd8;

    localparam int tx_ok_bit = 6; // set when the TX register can take a byte.
    localparam int rx_ok_bit = 7; // set when the RX register holds a byte.

    // one registered master request, unpacked onto the Avalon ports.
    typedef struct packed {
        logic [4:0]  address;
        logic        read;
        logic        write;
        logic [31:0] writedata;
    } avm_req_t;

endpackage

//--- rtl/rsa_pkg.sv
package rsa_pkg;

    localparam int key_width = 256;
    localparam int key_bytes = 32;  // bytes read for n, d and each ciphertext.
    localparam int out_bytes = 31;  // bytes sent back for each block.

    typedef struct packed {
        logic [key_width-1:0] base;
        logic [key_width-1:0] d;
        logic [key_width-1:0] n;
    } rsa_operands_t;

    typedef enum logic [2:0] {
        poll_rx,
        read_byte,
        start_calc,
        wait_calc,
        poll_tx,
        write_byte
    } wrap_state_e;

    typedef enum logic [1:0] {idle, prep, loop, done} core_state_e;

    // which operand the incoming RX bytes are shifted into.
    typedef enum logic [1:0] {load_n, load_d, load_data} load_phase_e;

endpackage

//--- rtl/rsa_mont_mul.sv
`timescale 1ns/1ps

module rsa_mont_mul (
    input  logic                          avm_clk,
    input  logic                          avm_rst,
    input  logic                          start,
    input  logic [rsa_pkg::key_width-1:0] a,
    input  logic [rsa_pkg::key_width-1:0] b,
    input  logic [rsa_pkg::key_width-1:0] n,
    output logic [rsa_pkg::key_width-1:0] result,
    output logic                          done
);
    import rsa_pkg::*;

    // b and n stay stable for the whole product, so only a is copied in.
    logic [key_width+1:0] acc;
    logic [key_width-1:0] a_sh;
    logic [7:0]           bit_cnt;
    logic                 busy;
    logic                 last;
    logic [key_width+1:0] sum_b;
    logic [key_width+1:0] sum_q;
    logic [key_width+1:0] acc_nxt;
    logic [key_width+1:0] acc_red;

    // acc stays below 2n, so the sum never needs more than 258 bits.
    always_comb begin
        sum_b   = acc + (a_sh[0] ? {2'b00, b} : '0);
        sum_q   = sum_b + (sum_b[0] ? {2'b00, n} : '0); // make it even.
        acc_nxt = sum_q >> 1;
        acc_red = acc_nxt - {2'b00, n};
    end

    assign last = busy && (bit_cnt == 8'hff);

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            done    <= 1'b0;
        end else begin
            done <= last;
            if (start) begin
                busy    <= 1'b1;
                bit_cnt <= '0;
            end else if (busy) begin
                bit_cnt <= bit_cnt + 8'd1;
                if (last) busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (start) begin
            acc  <= '0;
            a_sh <= a;
        end else if (busy) begin
            acc  <= acc_nxt;
            a_sh <= a_sh >> 1;
        end
        if (last) begin
            // one conditional subtract brings the product below n.
            result <= (acc_nxt >= {2'b00, n}) ? acc_red[key_width-1:0]
                                              : acc_nxt[key_width-1:0];
        end
    end

    a_result_below_n: assert property (@(posedge avm_clk) disable iff (avm_rst)
        done |-> result < n);

endmodule

//--- rtl/rsa_mod_prod.sv
`timescale 1ns/1ps

module rsa_mod_prod (
    input  logic                          avm_clk,
    input  logic                          avm_rst,
    input  logic                          start,
    input  logic [rsa_pkg::key_width-1:0] b,
    input  logic [rsa_pkg::key_width-1:0] n,
    output logic [rsa_pkg::key_width-1:0] result,
    output logic                          done
);
    import rsa_pkg::*;

    logic [key_width-1:0] val;
    logic [key_width:0]   dbl;
    logic [key_width:0]   dbl_red;
    logic [7:0]           dbl_cnt;
    logic                 busy;

    assign dbl     = {val, 1'b0};
    assign dbl_red = dbl - {1'b0, n};
    assign result  = val;

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            busy    <= 1'b0;
            dbl_cnt <= '0;
            done    <= 1'b0;
        end else begin
            done <= busy && (dbl_cnt == 8'hff);
            if (start) begin
                busy    <= 1'b1;
                dbl_cnt <= '0;
            end else if (busy) begin
                dbl_cnt <= dbl_cnt + 8'd1;
                if (dbl_cnt == 8'hff) busy <= 1'b0; // 256 doublings give b * 2^256.
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (start) val <= b;
        else if (busy) val <= (dbl >= {1'b0, n}) ? dbl_red[key_width-1:0] : dbl[key_width-1:0];
    end

    a_value_below_n: assert property (@(posedge avm_clk) disable iff (avm_rst)
        busy |-> val < n);

endmodule

//--- rtl/rsa_core.sv
`timescale 1ns/1ps

module rsa_core (
    input  logic                          avm_clk,
    input  logic                          avm_rst,
    input  logic                          start,
    input  rsa_pkg::rsa_operands_t        ops,
    output logic [rsa_pkg::key_width-1:0] result,
    output logic                          finished
);
    import rsa_pkg::*;

    core_state_e          state;
    logic [8:0]           step;       // exponent bit, 256 marks the exit product.
    logic                 last_step;
    logic                 prod_start;
    logic                 mm_start;
    logic                 prod_done;
    logic                 mul_done;
    logic [key_width-1:0] prod_result;
    logic [key_width-1:0] mul_result;
    logic [key_width-1:0] sqr_result;
    logic [key_width-1:0] acc;
    logic [key_width-1:0] sq;
    logic [key_width-1:0] mul_b;

    assign last_step = step[8];
    assign mul_b     = last_step ? key_width'(1) : sq; // times 1 leaves Montgomery form.
    assign finished  = (state == done);

    rsa_mod_prod u_mod_prod (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (prod_start),
        .b       (ops.base),
        .n       (ops.n),
        .result  (prod_result),
        .done    (prod_done)
    );

    rsa_mont_mul u_mul (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (mm_start),
        .a       (acc),
        .b       (mul_b),
        .n       (ops.n),
        .result  (mul_result),
        .done    (mul_done)
    );

    // the square shares the start of the multiply and finishes on the same cycle.
    rsa_mont_mul u_sqr (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (mm_start),
        .a       (sq),
        .b       (sq),
        .n       (ops.n),
        .result  (sqr_result),
        .done    ()
    );

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state      <= idle;
            step       <= '0;
            prod_start <= 1'b0;
            mm_start   <= 1'b0;
        end else begin
            prod_start <= 1'b0;
            mm_start   <= 1'b0;
            case (state)
                idle: begin
                    if (start) begin
                        state      <= prep;
                        step       <= '0;
                        prod_start <= 1'b1;
                    end
                end
                prep: begin
                    if (prod_done) begin
                        state    <= loop;
                        mm_start <= 1'b1;
                    end
                end
                loop: begin
                    if (mul_done && last_step) begin
                        state <= done;
                    end else if (mul_done) begin
                        step     <= step + 9'd1;
                        mm_start <= 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge avm_clk) begin
        // 2^256 - n is 1 in Montgomery form, since the top bit of n is set.
        if (state == idle && start) acc <= -ops.n;
        if (state == prep && prod_done) sq <= prod_result;
        if (state == loop && mul_done) begin
            if (last_step) begin
                result <= mul_result;
            end else begin
                if (ops.d[step[7:0]]) acc <= mul_result;
                sq <= sqr_result;
            end
        end
    end

    a_start_when_idle: assert property (@(posedge avm_clk) disable iff (avm_rst)
        start |-> state == idle);

endmodule

//--- rtl/rsa_wrapper.sv
`timescale 1ns/1ps

module rsa_wrapper (
    input  logic        avm_rst,
    input  logic        avm_clk,
    output logic [4:0]  avm_address,
    output logic        avm_read,
    input  logic [31:0] avm_readdata,
    output logic        avm_write,
    output logic [31:0] avm_writedata,
    input  logic        avm_waitrequest
);
    import avm_pkg::*;
    import rsa_pkg::*;

    avm_req_t             req;
    wrap_state_e          state;
    load_phase_e          phase;
    logic [4:0]           byte_cnt;
    rsa_operands_t        ops;
    logic [key_width-1:0] dec;
    logic                 core_start;
    logic                 core_finished;
    logic [key_width-1:0] core_result;
    logic                 rd_done;
    logic                 wr_done;

    assign avm_address   = req.address;
    assign avm_read      = req.read;
    assign avm_write     = req.write;
    assign avm_writedata = req.writedata;

    assign rd_done = req.read && !avm_waitrequest;
    assign wr_done = req.write && !avm_waitrequest;

    rsa_core u_core (
        .avm_clk  (avm_clk),
        .avm_rst  (avm_rst),
        .start    (core_start),
        .ops      (ops),
        .result   (core_result),
        .finished (core_finished)
    );

    // a request is only raised from an idle bus, which gives the gap cycle between transfers.
    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state      <= poll_rx;
            phase      <= load_n;
            byte_cnt   <= '0;
            req        <= '{address: status_base, read: 1'b0, write: 1'b0, writedata: '0};
            core_start <= 1'b0;
        end else begin
            core_start <= 1'b0;
            case (state)
                poll_rx: begin
                    if (!req.read) begin
                        req.address <= status_base;
                        req.read    <= 1'b1;
                    end else if (rd_done) begin
                        req.read <= 1'b0;
                        if (avm_readdata[rx_ok_bit]) state <= read_byte;
                    end
                end
                read_byte: begin
                    if (!req.read) begin
                        req.address <= rx_base;
                        req.read    <= 1'b1;
                    end else if (rd_done) begin
                        req.read <= 1'b0;
                        byte_cnt <= byte_cnt + 5'd1;
                        state    <= poll_rx;
                        if (byte_cnt == 5'(key_bytes - 1)) begin
                            byte_cnt <= '0;
                            case (phase)
                                load_n:  phase <= load_d;
                                load_d:  phase <= load_data;
                                default: state <= start_calc; // keys stay loaded.
                            endcase
                        end
                    end
                end
                start_calc: begin
                    core_start <= 1'b1;
                    state      <= wait_calc;
                end
                wait_calc: begin
                    if (core_finished) state <= poll_tx;
                end
                poll_tx: begin
                    if (!req.read) begin
                        req.address <= status_base;
                        req.read    <= 1'b1;
                    end else if (rd_done) begin
                        req.read <= 1'b0;
                        if (avm_readdata[tx_ok_bit]) state <= write_byte;
                    end
                end
                write_byte: begin
                    if (!req.write) begin
                        req.address   <= tx_base;
                        req.write     <= 1'b1;
                        req.writedata <= {24'd0, dec[key_width-9 -: 8]};
                    end else if (wr_done) begin
                        req.write <= 1'b0;
                        byte_cnt  <= byte_cnt + 5'd1;
                        state     <= poll_tx;
                        if (byte_cnt == 5'(out_bytes - 1)) begin
                            byte_cnt <= '0;
                            state    <= poll_rx;
                        end
                    end
                end
                default: state <= poll_rx;
            endcase
        end
    end

    always_ff @(posedge avm_clk) begin
        if (state == read_byte && rd_done) begin
            case (phase) // bytes arrive most significant first.
                load_n:  ops.n    <= {ops.n[key_width-9:0], avm_readdata[7:0]};
                load_d:  ops.d    <= {ops.d[key_width-9:0], avm_readdata[7:0]};
                default: ops.base <= {ops.base[key_width-9:0], avm_readdata[7:0]};
            endcase
        end
        if (state == wait_calc && core_finished) dec <= core_result;
        else if (state == write_byte && wr_done) dec <= dec << 8;
    end

    a_one_direction: assert property (@(posedge avm_clk) disable iff (avm_rst)
        !(avm_read && avm_write));

    a_hold_request: assert property (@(posedge avm_clk) disable iff (avm_rst)
        (avm_read || avm_write) && avm_waitrequest |=> $stable(req));

endmodule

//--- testbench/rs232_model.sv
`timescale 1ns/1ps

module rs232_model (
    input  logic        avm_clk,
    input  logic        avm_rst,
    input  logic [4:0]  address,
    input  logic        read,
    input  logic        write,
    input  logic [31:0] writedata,
    output logic [31:0] readdata,
    output logic        waitrequest,
    input  logic        push_valid,
    input  logic [7:0]  push_byte,
    output logic        tx_valid,
    output logic [7:0]  tx_byte,
    output int          rx_reads,
    output int          tx_writes,
    output int          rx_left,
    output int          errors
);
    import avm_pkg::*;

    logic [7:0]  rx_q[$];
    logic [31:0] lfsr;
    logic        rx_seen; // rx_ok as shown by the last status read.
    logic        tx_seen;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    always @(posedge avm_clk or posedge avm_rst) begin
        logic [31:0] status_word;
        if (avm_rst) begin
            lfsr = 32'he27a;
            waitrequest <= 1'b1;
            readdata    <= '0;
            tx_valid    <= 1'b0;
            tx_byte     <= '0;
            rx_seen     <= 1'b0;
            tx_seen     <= 1'b0;
            rx_reads    <= 0;
            tx_writes   <= 0;
            errors      <= 0;
        end else begin
            tx_valid <= 1'b0;
            if ((read || write) && !waitrequest) begin
                waitrequest <= 1'b1; // the transfer completes on this edge.
                if (read && address == status_base) begin
                    rx_seen <= readdata[rx_ok_bit];
                    tx_seen <= readdata[tx_ok_bit];
                end else if (read && address == rx_base) begin
                    rx_seen  <= 1'b0;
                    rx_reads <= rx_reads + 1;
                    if (!rx_seen || rx_q.size() == 0) begin
                        $display("bus error at %0t: RX read without a byte ready", $time);
                        errors <= errors + 1;
                    end
                    if (rx_q.size() > 0) void'(rx_q.pop_front());
                end else if (write && address == tx_base) begin
                    tx_seen   <= 1'b0;
                    tx_writes <= tx_writes + 1;
                    tx_valid  <= 1'b1;
                    tx_byte   <= writedata[7:0];
                    if (!tx_seen) begin
                        $display("bus error at %0t: TX write while TX was not ready", $time);
                        errors <= errors + 1;
                    end
                end else begin
                    $display("bus error at %0t: bad access to address %0d", $time, address);
                    errors <= errors + 1;
                end
            end else if ((read || write) && waitrequest) begin
                lfsr = lfsr_next(lfsr);
                if (lfsr[0]) begin
                    waitrequest <= 1'b0;
                    if (address == status_base) begin
                        status_word = '0;
                        lfsr = lfsr_next(lfsr);
                        status_word[rx_ok_bit] = lfsr[0] && (rx_q.size() > 0);
                        lfsr = lfsr_next(lfsr);
                        status_word[tx_ok_bit] = lfsr[0];
                        readdata <= status_word;
                    end else begin
                        readdata <= (rx_q.size() > 0) ? {24'd0, rx_q[0]} : '0;
                    end
                end
            end
            if (push_valid) rx_q.push_back(push_byte);
        end
        rx_left <= rx_q.size();
    end

endmodule

//--- testbench/tb_rsa.sv
`timescale 1ns/1ps

module tb_rsa;
    import rsa_pkg::*;

    typedef struct packed {
        logic [key_width-1:0] n;
        logic [key_width-1:0] d;
        logic [key_width-1:0] c;
    } vector_t;

    localparam int num_blocks     = 3;
    localparam int timeout_cycles = 3 * num_blocks * 140000;
    localparam logic [key_width-1:0] key_n =
        256'hc5b7_2e91_4f0a_d863_17ce_9b42_a06f_e5d1_3b88_74c2_09fa_6e15_d2b3_4a97_e061_5c2f;
    localparam logic [key_width-1:0] key_d =
        256'h5e03_9a7c_11d4_b862_f0e9_3c57_2a18_d6b4_8f21_07ec_4b96_a3d0_7c5e_1f82_b94a_6d31;

    logic        avm_clk;
    logic        avm_rst;
    logic [4:0]  avm_address;
    logic        avm_read;
    logic [31:0] avm_readdata;
    logic        avm_write;
    logic [31:0] avm_writedata;
    logic        avm_waitrequest;
    logic        push_valid;
    logic [7:0]  push_byte;
    logic        tx_valid;
    logic [7:0]  tx_byte;
    int          rx_reads;
    int          tx_writes;
    int          rx_left;
    int          model_errors;
    int          err_cnt;
    int          cycle_cnt;
    vector_t     vectors [num_blocks];

    rsa_wrapper i_dut (
        .avm_rst         (avm_rst),
        .avm_clk         (avm_clk),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_readdata    (avm_readdata),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_waitrequest (avm_waitrequest)
    );

    rs232_model i_model (
        .avm_clk     (avm_clk),
        .avm_rst     (avm_rst),
        .address     (avm_address),
        .read        (avm_read),
        .write       (avm_write),
        .writedata   (avm_writedata),
        .readdata    (avm_readdata),
        .waitrequest (avm_waitrequest),
        .push_valid  (push_valid),
        .push_byte   (push_byte),
        .tx_valid    (tx_valid),
        .tx_byte     (tx_byte),
        .rx_reads    (rx_reads),
        .tx_writes   (tx_writes),
        .rx_left     (rx_left),
        .errors      (model_errors)
    );

    initial begin
        avm_clk = 1'b0;
        forever #2 avm_clk = ~avm_clk;
    end

    // plain square-and-multiply, wide enough that no product overflows.
    function automatic logic [key_width-1:0] mod_exp(input logic [key_width-1:0] base,
                                                     input logic [key_width-1:0] e,
                                                     input logic [key_width-1:0] m);
        logic [511:0] r;
        logic [511:0] b;
        logic [511:0] mw;
        int           i;
        mw = {256'd0, m};
        r  = 512'd1;
        b  = {256'd0, base} % mw;
        for (i = 0; i < key_width; i++) begin
            if (e[i]) r = (r * b) % mw;
            b = (b * b) % mw;
        end
        return r[key_width-1:0];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERROR at %0t: %s is %0h, expected %0h", $time, name, got, expected);
            err_cnt++;
        end
    endtask

    task automatic push_operand(input logic [key_width-1:0] value);
        int i;
        for (i = key_bytes - 1; i >= 0; i--) begin
            @(posedge avm_clk);
            push_valid <= 1'b1;
            push_byte  <= value[8*i +: 8];
        end
    endtask

    initial begin
        logic [key_width-1:0] plain;
        int                   blk;
        int                   k;
        avm_rst    = 1'b1;
        push_valid = 1'b0;
        push_byte  = '0;
        err_cnt    = 0;
        // all blocks share the keys loaded after reset.
        vectors[0] = '{n: key_n, d: key_d, c:
            256'h0123_4567_89ab_cdef_fedc_ba98_7654_3210_0f1e_2d3c_4b5a_6978_8796_a5b4_c3d2_e1f0};
        vectors[1] = '{n: key_n, d: key_d, c:
            256'hb4f2_9e01_7d3a_c586_2b19_e4d7_60af_83c2_5d1e_9b07_f4a6_382c_e159_0d7b_a6f3_4c88};
        vectors[2] = '{n: key_n, d: key_d, c: 256'd2};
        repeat (8) begin
            @(negedge avm_clk);
            check_value("avm_read", 32'(avm_read), 32'd0);
            check_value("avm_write", 32'(avm_write), 32'd0);
        end
        @(posedge avm_clk);
        avm_rst <= 1'b0;
        push_operand(vectors[0].n);
        push_operand(vectors[0].d);
        for (blk = 0; blk < num_blocks; blk++) push_operand(vectors[blk].c);
        @(posedge avm_clk);
        push_valid <= 1'b0;
        for (blk = 0; blk < num_blocks; blk++) begin
            plain = mod_exp(vectors[blk].c, vectors[blk].d, vectors[blk].n);
            for (k = 0; k < out_bytes; k++) begin
                do @(negedge avm_clk); while (!tx_valid);
                check_value("tx byte", 32'(tx_byte), 32'(plain[8*(out_bytes-1-k) +: 8]));
            end
        end
        repeat (200) @(posedge avm_clk); // the wrapper keeps polling an empty RX queue.
        check_value("rx reads", rx_reads, (2 + num_blocks) * key_bytes);
        check_value("tx writes", tx_writes, num_blocks * out_bytes);
        check_value("rx bytes left", rx_left, 0);
        $display("run complete: %0d mismatches, %0d bus errors", err_cnt, model_errors);
        if (err_cnt == 0 && model_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < timeout_cycles) begin
            @(posedge avm_clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles with %0d bytes sent", cycle_cnt, tx_writes);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- list.f
rtl/avm_pkg.sv
rtl/rsa_pkg.sv
rtl/rsa_mont_mul.sv
rtl/rsa_mod_prod.sv
rtl/rsa_core.sv
rtl/rsa_wrapper.sv
testbench/rs232_model.sv
testbench/tb_rsa.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_rsa
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
